// ==== sim/tb_hub75_input.txt ====
# W addr data [resp] : bus write, resp 0 OKAY or 2 SLVERR, default OKAY
# R addr data resp : bus read with expected data | B key : fill framebuffer | F n : frames
R 000 00000000 0
R 004 00000000 0
W 100 12345678 2
R 100 00000000 2
R 800 00000000 2
R 400 00000000 0
B 005a3c
W 404 00fedcba
W 5fc 00123456
W 000 00000001
R 000 00000001 0
R 404 00000000 0
F 2
W 000 00000000
R 000 00000000 0
W 000 00000001
F 1
W 000 00000000

// ==== vlog.f ====
src/hub75_pkg.sv
src/hub75_axil_regs.sv
src/hub75_framebuf.sv
src/hub75_scan.sv
src/hub75_phy.sv
src/hub75_top.sv
sim/tb_hub75_top.sv

// ==== Makefile ====
# Verilator build for the HUB75 driver testbench

VERILATOR ?= verilator
FLAGS     ?= --binary --timing -j 0
TOP       ?= tb_hub75_top
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Everything OK

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== sim/tb_hub75_top.sv ====
/*
 * Testbench for the HUB75 driver, commands come from sim/tb_hub75_input.txt
 * Pads are sampled on the falling clock edge, bus inputs change on the rising edge
 * Framebuffer must be fully loaded before enable is set
 */
`timescale 1ns/10ps

module tb_hub75_top;
	import hub75_pkg::*;

	localparam int CLK_PERIOD = 10;
	// Cycles per frame, 37 per plane for shift, blank and latch plus the on time
	localparam int FRAME_LEN = N_ROWS * (BITDEPTH * (2 * N_COLS + 5) +
		ON_BASE * ((1 << BITDEPTH) - 1));
	localparam int CMD_SLACK = 4000;

	logic                    clk;
	logic                    rst;
	logic [AXI_ADDR_W-1:0]   awaddr;
	logic                    awvalid;
	logic                    awready;
	logic [AXI_DATA_W-1:0]   wdata;
	logic [AXI_DATA_W/8-1:0] wstrb;
	logic                    wvalid;
	logic                    wready;
	resp_t                   bresp;
	logic                    bvalid;
	logic                    bready;
	logic [AXI_ADDR_W-1:0]   araddr;
	logic                    arvalid;
	logic                    arready;
	logic [AXI_DATA_W-1:0]   rdata;
	resp_t                   rresp;
	logic                    rvalid;
	logic                    rready;
	logic [LOG_N_ROWS-1:0]   hub75_addr;
	logic [SDW-1:0]          hub75_data;
	logic                    hub75_clk;
	logic                    hub75_le;
	logic                    hub75_blank;

	// Image model, one word per framebuffer address
	logic [PIX_W-1:0] img [0:N_ROWS*N_COLS-1];
	logic [SDW-1:0]   shift_q [$];
	// Pad monitor state
	logic           clk_q;
	logic           le_q;
	logic           blank_q;
	logic [SDW-1:0] data_q;
	int   on_len;
	int   mon_row = 0;
	int   mon_plane = 0;
	int   mon_frames = 0;
	int   clk_edges = 0;
	int   unblank_total = 0;
	// Results
	int    errors = 0;
	int    pass_cnt = 0;
	int    fail_cnt = 0;
	int    test_err0;
	logic  en_model = 1'b0;
	time   deadline = 1000 * CLK_PERIOD;

	hub75_top i_hub75_top (.*);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// Watchdog, deadline moves on with every command
	initial begin
		forever begin
			@(posedge clk);
			if ($time > deadline) begin
				$display("Timeout, the DUT stopped responding or frames never completed");
				$display("Something failed");
				$finish;
			end
		end
	end

	task automatic check_resp(input string name, input resp_t got, input resp_t exp);
		if (got !== exp) begin
			errors++;
			$display("FAILED at %0t: %s got %s expected %s", $time, name, got.name(), exp.name());
		end
	endtask

	task automatic check_data(input string name, input logic [AXI_DATA_W-1:0] got,
			input logic [AXI_DATA_W-1:0] exp);
		if (got !== exp) begin
			errors++;
			$display("FAILED at %0t: %s got %08h expected %08h", $time, name, got, exp);
		end
	endtask

	task automatic check_pix(input string name, input logic [SDW-1:0] got,
			input logic [SDW-1:0] exp);
		if (got !== exp) begin
			errors++;
			$display("FAILED at %0t: %s got %02h expected %02h", $time, name, got, exp);
		end
	endtask

	task automatic check_count(input string name, input int got, input int exp);
		if (got != exp) begin
			errors++;
			$display("FAILED at %0t: %s got %0d expected %0d", $time, name, got, exp);
		end
	endtask

	// Latched row and the 16 columns shifted before it
	task automatic check_line();
		int idx;
		check_count("hub75_addr at latch", int'(hub75_addr), mon_row);
		check_count("hub75_clk edges per line", shift_q.size(), N_COLS);
		for (int c = 0; c < N_COLS && c < shift_q.size(); c++) begin
			idx = mon_row * N_COLS + c;
			check_pix($sformatf("hub75_data r%0d p%0d c%0d", mon_row, mon_plane, c),
				shift_q[c], img[idx][mon_plane*SDW +: SDW]);
		end
		shift_q.delete();
	endtask

	// End of an unblanked period, then step to the next plane
	task automatic check_on();
		check_count($sformatf("hub75_blank low r%0d p%0d", mon_row, mon_plane), on_len,
			ON_BASE << mon_plane);
		on_len = 0;
		mon_plane++;
		if (mon_plane == BITDEPTH) begin
			mon_plane = 0;
			mon_row++;
			if (mon_row == N_ROWS) begin
				mon_row = 0;
				mon_frames++;
			end
		end
	endtask

	// Pad monitor
	always @(negedge clk) begin
		if (rst) begin
			clk_q   = 1'b0;
			le_q    = 1'b0;
			blank_q = 1'b1;
			data_q  = '0;
			on_len  = 0;
		end else begin
			// Panel shifts in the data held before the clock rise
			if (hub75_clk && !clk_q) begin
				clk_edges++;
				shift_q.push_back(data_q);
			end
			if (hub75_le && !le_q)
				check_line();
			if (!hub75_blank) begin
				on_len++;
				unblank_total++;
			end else if (!blank_q) begin
				check_on();
			end
			clk_q   = hub75_clk;
			le_q    = hub75_le;
			blank_q = hub75_blank;
			data_q  = hub75_data;
		end
	end

	task automatic bus_write(input logic [AXI_ADDR_W-1:0] addr,
			input logic [AXI_DATA_W-1:0] data, output resp_t resp);
		@(posedge clk);
		awaddr  <= addr;
		wdata   <= data;
		awvalid <= 1'b1;
		wvalid  <= 1'b1;
		do @(negedge clk); while (!awready);
		// Address and data are taken in the same cycle
		check_data("wready", 32'(wready), 32'd1);
		@(posedge clk);
		awvalid <= 1'b0;
		wvalid  <= 1'b0;
		do @(negedge clk); while (!bvalid);
		resp = bresp;
	endtask

	task automatic bus_read(input logic [AXI_ADDR_W-1:0] addr,
			output logic [AXI_DATA_W-1:0] data, output resp_t resp);
		@(posedge clk);
		araddr  <= addr;
		arvalid <= 1'b1;
		do @(negedge clk); while (!arready);
		@(posedge clk);
		arvalid <= 1'b0;
		do @(negedge clk); while (!rvalid);
		data = rdata;
		resp = rresp;
	endtask

	task automatic end_test(input string name);
		if (errors == test_err0) begin
			pass_cnt++;
			$display("PASS %s", name);
		end else begin
			fail_cnt++;
			$display("FAIL %s", name);
		end
	endtask

	// Write command, keeps the image model and the enable state in step
	task automatic do_write(input logic [AXI_ADDR_W-1:0] addr,
			input logic [AXI_DATA_W-1:0] data, input resp_t exp);
		resp_t resp;
		int    e0;
		int    b0;
		if (addr == REG_CTRL && data[0] && !en_model) begin
			mon_row   = 0;
			mon_plane = 0;
		end
		bus_write(addr, data, resp);
		check_resp($sformatf("bresp @%03h", addr), resp, exp);
		// Word aligned hit in the 128 word framebuffer window
		if (addr >= FB_BASE && addr < FB_BASE + AXI_ADDR_W'(4 * N_ROWS * N_COLS) &&
				addr[1:0] == 2'b00)
			img[addr[FB_ADDR_W+1:2]] = data[PIX_W-1:0];
		if (addr == REG_CTRL) begin
			if (!data[0] && en_model) begin
				// Let the current plane finish, then the panel must stay dark
				repeat (2 * N_COLS + 13 + (ON_BASE << (BITDEPTH - 1))) @(posedge clk);
				e0 = clk_edges;
				b0 = unblank_total;
				repeat (300) @(posedge clk);
				check_count("hub75_clk edges after disable", clk_edges - e0, 0);
				check_count("unblanked cycles after disable", unblank_total - b0, 0);
			end
			en_model = data[0];
		end
	endtask

	initial begin
		int                    fd;
		int                    n;
		int                    e0;
		string                 line;
		logic [31:0]           f1;
		logic [31:0]           f2;
		logic [31:0]           f3;
		logic [AXI_ADDR_W-1:0] addr;
		logic [AXI_DATA_W-1:0] got;
		logic [PIX_W-1:0]      pix;
		resp_t                 resp;
		int                    target;

		rst = 1'b1;
		awaddr = '0;
		awvalid = 1'b0;
		wdata = '0;
		wstrb = '1;
		wvalid = 1'b0;
		bready = 1'b1;
		araddr = '0;
		arvalid = 1'b0;
		rready = 1'b1;
		repeat (4) @(posedge clk);
		rst <= 1'b0;

		// Reset state and idle pads
		test_err0 = errors;
		@(negedge clk);
		check_data("hub75_blank", 32'(hub75_blank), 32'd1);
		check_data("hub75_clk", 32'(hub75_clk), 32'd0);
		check_data("hub75_le", 32'(hub75_le), 32'd0);
		e0 = clk_edges;
		repeat (50) @(posedge clk);
		check_count("hub75_clk edges while disabled", clk_edges - e0, 0);
		end_test("reset state");

		fd = $fopen("sim/tb_hub75_input.txt", "r");
		if (fd == 0) begin
			errors++;
			$display("Could not open the command file sim/tb_hub75_input.txt");
		end
		while (fd != 0 && !$feof(fd)) begin
			line = "";
			void'($fgets(line, fd));
			if (line.len() < 2 || line.getc(0) == "#")
				continue;
			n = $sscanf(line.substr(1, line.len() - 1), "%h %h %h", f1, f2, f3);
			test_err0 = errors;
			deadline = $time + 64'(CMD_SLACK * CLK_PERIOD);
			addr = f1[AXI_ADDR_W-1:0];
			case (line.getc(0))
				"W": begin
					do_write(addr, f2, (n >= 3) ? resp_t'(f3[1:0]) : RESP_OKAY);
					end_test($sformatf("write %03h", addr));
				end
				"R": begin
					bus_read(addr, got, resp);
					check_data($sformatf("rdata @%03h", addr), got, f2);
					check_resp($sformatf("rresp @%03h", addr), resp, resp_t'(f3[1:0]));
					end_test($sformatf("read %03h", addr));
				end
				// Fill every framebuffer word, pattern depends on the full address
				"B": begin
					for (int a = 0; a < N_ROWS * N_COLS; a++) begin
						pix = PIX_W'((a * 32'h0001_3579) ^ (a << 17) ^ f1);
						do_write(FB_BASE + AXI_ADDR_W'(a * 4), 32'(pix), RESP_OKAY);
					end
					end_test("framebuffer load");
				end
				"F": begin
					deadline = $time + 64'((f1 * FRAME_LEN + CMD_SLACK) * CLK_PERIOD);
					target = mon_frames + int'(f1);
					while (mon_frames < target)
						@(posedge clk);
					bus_read(REG_STATUS, got, resp);
					check_resp("rresp STATUS", resp, RESP_OKAY);
					if (got < 32'(target)) begin
						errors++;
						$display("FAILED at %0t: rdata STATUS got %0d expected at least %0d",
							$time, got, target);
					end
					end_test($sformatf("%0d frames", f1));
				end
				default: begin
					errors++;
					$display("Unknown command in the command file: %s", line);
				end
			endcase
		end
		if (fd != 0)
			$fclose(fd);

		$display("Tests passed: %0d, failed: %0d, check errors: %0d", pass_cnt, fail_cnt,
			errors);
		if (errors == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

endmodule

// ==== src/hub75_top.sv ====
/*
 * HUB75 driver top, AXI4-Lite in, panel pads out
 * Pads lag the scan engine by one cycle, the shift clock by two
 * Single clock domain, bus and scan share clk
 */
`timescale 1ns/10ps

module hub75_top (
	input  logic                                clk,
	input  logic                                rst,
	// AXI4-Lite slave
	input  logic [hub75_pkg::AXI_ADDR_W-1:0]    awaddr,
	input  logic                                awvalid,
	output logic                                awready,
	input  logic [hub75_pkg::AXI_DATA_W-1:0]    wdata,
	input  logic [hub75_pkg::AXI_DATA_W/8-1:0]  wstrb,
	input  logic                                wvalid,
	output logic                                wready,
	output hub75_pkg::resp_t                    bresp,
	output logic                                bvalid,
	input  logic                                bready,
	input  logic [hub75_pkg::AXI_ADDR_W-1:0]    araddr,
	input  logic                                arvalid,
	output logic                                arready,
	output logic [hub75_pkg::AXI_DATA_W-1:0]    rdata,
	output hub75_pkg::resp_t                    rresp,
	output logic                                rvalid,
	input  logic                                rready,
	// Panel pads
	output logic [hub75_pkg::LOG_N_ROWS-1:0]    hub75_addr,
	output logic [hub75_pkg::SDW-1:0]           hub75_data,
	output logic                                hub75_clk,
	output logic                                hub75_le,
	output logic                                hub75_blank
);
	import hub75_pkg::*;

	// Control between bus slave and scan engine
	logic                  enable;
	logic                  frame_done;
	// Framebuffer ports
	logic                  fb_we;
	logic [FB_ADDR_W-1:0]  fb_waddr;
	logic [PIX_W-1:0]      fb_wdata;
	logic [FB_ADDR_W-1:0]  fb_raddr;
	logic [PIX_W-1:0]      fb_rdata;
	// Scan engine to PHY
	logic [LOG_N_ROWS-1:0] phy_addr;
	logic [SDW-1:0]        phy_data;
	logic                  phy_clk;
	logic                  phy_le;
	logic                  phy_blank;

	// Names match one to one on the slave, scan and PHY
	hub75_axil_regs i_regs (.*);

	hub75_framebuf i_framebuf (
		.clk   (clk),
		.we    (fb_we),
		.waddr (fb_waddr),
		.raddr (fb_raddr),
		.wdata (fb_wdata),
		.rdata (fb_rdata)
	);

	hub75_scan i_scan (.*);

	hub75_phy i_phy (.*);

endmodule

// ==== src/hub75_phy.sv ====
/*
 * Pad output stage, plain registers in place of the I/O cell flops
 * Address, data, latch and blank lag their inputs by one cycle
 * Shift clock lags by two, one extra stage so it rises after its data
 * Blank resets high so the panel stays dark out of reset
 */
`timescale 1ns/10ps

module hub75_phy (
	input  logic                             clk,
	input  logic                             rst,
	// From the scan engine
	input  logic [hub75_pkg::LOG_N_ROWS-1:0] phy_addr,
	input  logic [hub75_pkg::SDW-1:0]        phy_data,
	input  logic                             phy_clk,
	input  logic                             phy_le,
	input  logic                             phy_blank,
	// Pads
	output logic [hub75_pkg::LOG_N_ROWS-1:0] hub75_addr,
	output logic [hub75_pkg::SDW-1:0]        hub75_data,
	output logic                             hub75_clk,
	output logic                             hub75_le,
	output logic                             hub75_blank
);
	// Extra delay stage for the shift clock
	logic clk_dly;

	// Pad registers
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			hub75_addr  <= '0;
			hub75_data  <= '0;
			hub75_le    <= 1'b0;
			hub75_blank <= 1'b1;
		end else begin
			hub75_addr  <= phy_addr;
			hub75_data  <= phy_data;
			hub75_le    <= phy_le;
			hub75_blank <= phy_blank;
		end
	end

	// Shift clock, two stages
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			clk_dly   <= 1'b0;
			hub75_clk <= 1'b0;
		end else begin
			clk_dly   <= phy_clk;
			hub75_clk <= clk_dly;
		end
	end

endmodule

// ==== src/hub75_scan.sv ====
/*
 * BCM scan engine for a 16x8 two bank panel, planes 0 to 3 per row
 * Per plane: 16 columns at 2 cycles each, 2 blank, latch, 1 blank hold, on time
 * Blank is high everywhere except the on period
 * Disable is seen only at the end of a plane, the next start is row 0 plane 0
 */
`timescale 1ns/10ps

module hub75_scan (
	input  logic                             clk,
	input  logic                             rst,
	input  logic                             enable,
	output logic                             frame_done,
	// Framebuffer read port
	output logic [hub75_pkg::FB_ADDR_W-1:0]  fb_raddr,
	input  logic [hub75_pkg::PIX_W-1:0]      fb_rdata,
	// To the PHY
	output logic [hub75_pkg::LOG_N_ROWS-1:0] phy_addr,
	output logic [hub75_pkg::SDW-1:0]        phy_data,
	output logic                             phy_clk,
	output logic                             phy_le,
	output logic                             phy_blank
);
	import hub75_pkg::*;

	scan_state_t             state;
	logic [LOG_N_ROWS-1:0]   row;
	logic [LOG_N_ROWS-1:0]   row_nxt;
	logic [LOG_BITDEPTH-1:0] plane;
	logic [LOG_BITDEPTH-1:0] plane_nxt;
	logic [LOG_N_COLS-1:0]   col;
	logic [LOG_N_COLS-1:0]   col_rd;
	logic                    phase;
	logic [ON_W-1:0]         cnt;
	logic [ON_W-1:0]         on_len;
	logic                    last_col;
	logic                    last_plane;
	logic                    last_row;

	assign last_col   = col == LOG_N_COLS'(N_COLS - 1);
	assign last_plane = plane == LOG_BITDEPTH'(BITDEPTH - 1);
	assign last_row   = row == LOG_N_ROWS'(N_ROWS - 1);

	// Binary weighted on time
	assign on_len = ON_W'(ON_BASE) << plane;

	// Position after this plane, back to the top when disabled
	always_comb begin
		plane_nxt = plane + 1'b1;
		row_nxt   = row;
		if (last_plane) begin
			plane_nxt = '0;
			row_nxt   = last_row ? '0 : row + 1'b1;
		end
		if (!enable) begin
			plane_nxt = '0;
			row_nxt   = '0;
		end
	end

	// Read one cycle ahead
	// Clock high half already asks for the next column
	assign col_rd = phase ? col + 1'b1 : col;

	always_comb begin
		case (state)
			ST_SHIFT: fb_raddr = {row, col_rd};
			// Prefetch column 0 of the coming plane
			ST_NEXT:  fb_raddr = {row_nxt, LOG_N_COLS'(0)};
			default:  fb_raddr = {row, LOG_N_COLS'(0)};
		endcase
	end

	// Pad side strobes
	assign phy_clk    = (state == ST_SHIFT) && phase;
	assign phy_le     = (state == ST_LATCH) && (cnt == '0);
	assign phy_blank  = state != ST_ON;
	assign phy_data   = (state == ST_SHIFT) ? fb_rdata[plane*SDW +: SDW] : '0;
	assign frame_done = (state == ST_NEXT) && last_plane && last_row;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state    <= ST_IDLE;
			row      <= '0;
			plane    <= '0;
			col      <= '0;
			phase    <= 1'b0;
			cnt      <= '0;
			phy_addr <= '0;
		end else begin
			case (state)
				ST_IDLE: begin
					if (enable)
						state <= ST_SHIFT;
				end

				// Low half then high half of the shift clock
				ST_SHIFT: begin
					phase <= ~phase;
					if (phase) begin
						col <= col + 1'b1;
						if (last_col)
							state <= ST_BLANK;
					end
				end

				// Two blank cycles before the latch
				ST_BLANK: begin
					cnt <= cnt + 1'b1;
					if (cnt == ON_W'(1)) begin
						cnt      <= '0;
						phy_addr <= row;
						state    <= ST_LATCH;
					end
				end

				// Latch pulse, then one more blank cycle
				ST_LATCH: begin
					cnt <= cnt + 1'b1;
					if (cnt == ON_W'(1)) begin
						cnt   <= '0;
						state <= ST_ON;
					end
				end

				ST_ON: begin
					cnt <= cnt + 1'b1;
					if (cnt == on_len - 1'b1) begin
						cnt   <= '0;
						state <= ST_NEXT;
					end
				end

				// Advance plane and row, enable sampled here only
				ST_NEXT: begin
					plane <= plane_nxt;
					row   <= row_nxt;
					state <= enable ? ST_SHIFT : ST_IDLE;
				end

				default: state <= ST_IDLE;
			endcase
		end
	end

endmodule

// ==== src/hub75_framebuf.sv ====
/*
 * Framebuffer, one word per column of one row address for both banks
 * Simple dual port, read data registered, one cycle latency
 * No reset, contents undefined until written
 */
`timescale 1ns/10ps

module hub75_framebuf (
	input  logic                            clk,
	input  logic                            we,
	input  logic [hub75_pkg::FB_ADDR_W-1:0] waddr,
	input  logic [hub75_pkg::FB_ADDR_W-1:0] raddr,
	input  logic [hub75_pkg::PIX_W-1:0]     wdata,
	output logic [hub75_pkg::PIX_W-1:0]     rdata
);
	import hub75_pkg::*;

	// Row major, address is row * N_COLS + column
	logic [PIX_W-1:0] mem [0:N_ROWS*N_COLS-1];

	// Bus side write
	always_ff @(posedge clk) begin
		if (we)
			mem[waddr] <= wdata;
	end

	// Scan side read, old data on a same address collision
	always_ff @(posedge clk) begin
		rdata <= mem[raddr];
	end

endmodule

// ==== src/hub75_axil_regs.sv ====
/*
 * AXI4-Lite slave for the panel driver
 * One write and one read in flight at most, no new accept while a response waits
 * wstrb is ignored, every write covers the full word
 * Framebuffer window is write only, reads there return zero with OKAY
 */
`timescale 1ns/10ps

module hub75_axil_regs (
	input  logic                                clk,
	input  logic                                rst,
	// Write address and data
	input  logic [hub75_pkg::AXI_ADDR_W-1:0]    awaddr,
	input  logic                                awvalid,
	output logic                                awready,
	input  logic [hub75_pkg::AXI_DATA_W-1:0]    wdata,
	input  logic [hub75_pkg::AXI_DATA_W/8-1:0]  wstrb,
	input  logic                                wvalid,
	output logic                                wready,
	// Write response
	output hub75_pkg::resp_t                    bresp,
	output logic                                bvalid,
	input  logic                                bready,
	// Read address and data
	input  logic [hub75_pkg::AXI_ADDR_W-1:0]    araddr,
	input  logic                                arvalid,
	output logic                                arready,
	output logic [hub75_pkg::AXI_DATA_W-1:0]    rdata,
	output hub75_pkg::resp_t                    rresp,
	output logic                                rvalid,
	input  logic                                rready,
	// Scan engine side
	output logic                                enable,
	input  logic                                frame_done,
	// Framebuffer write port
	output logic                                fb_we,
	output logic [hub75_pkg::FB_ADDR_W-1:0]     fb_waddr,
	output logic [hub75_pkg::PIX_W-1:0]         fb_wdata
);
	import hub75_pkg::*;

	logic                  wr_hs;
	logic                  rd_hs;
	logic                  aw_ctrl;
	logic                  aw_fb;
	logic [AXI_DATA_W-1:0] rd_data;
	resp_t                 rd_resp;
	logic [FCNT_W-1:0]     frame_cnt;

	// Word aligned hit in the framebuffer window
	function automatic logic in_fb(input logic [AXI_ADDR_W-1:0] addr);
		return (addr[AXI_ADDR_W-1:FB_ADDR_W+2] == FB_BASE[AXI_ADDR_W-1:FB_ADDR_W+2]) &&
			(addr[1:0] == 2'b00);
	endfunction

	// Ready pulses last one cycle, so these are the accept cycles
	assign wr_hs = awready && awvalid && wvalid;
	assign rd_hs = arready && arvalid;

	assign aw_ctrl = awaddr == REG_CTRL;
	assign aw_fb   = in_fb(awaddr);

	// Read decode
	always_comb begin
		rd_data = '0;
		rd_resp = RESP_OKAY;
		if (araddr == REG_CTRL) begin
			rd_data[0] = enable;
		end else if (araddr == REG_STATUS) begin
			rd_data[FCNT_W-1:0] = frame_cnt;
		end else if (!in_fb(araddr)) begin
			rd_resp = RESP_SLVERR;
		end
	end

	// Handshake and control state
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			awready <= 1'b0;
			wready  <= 1'b0;
			bvalid  <= 1'b0;
			arready <= 1'b0;
			rvalid  <= 1'b0;
			enable  <= 1'b0;
			fb_we   <= 1'b0;
		end else begin
			awready <= 1'b0;
			wready  <= 1'b0;
			arready <= 1'b0;
			fb_we   <= 1'b0;

			// Accept address and data together, held off by a pending response
			if (!awready && awvalid && wvalid && !bvalid) begin
				awready <= 1'b1;
				wready  <= 1'b1;
			end
			if (wr_hs) begin
				bvalid <= 1'b1;
				if (aw_ctrl)
					enable <= wdata[0];
				else if (aw_fb)
					fb_we <= 1'b1;
			end else if (bready) begin
				bvalid <= 1'b0;
			end

			// Read side, same rule against rvalid
			if (!arready && arvalid && !rvalid)
				arready <= 1'b1;
			if (rd_hs)
				rvalid <= 1'b1;
			else if (rready)
				rvalid <= 1'b0;
		end
	end

	// Response and write payload, held until the next accept
	always_ff @(posedge clk) begin
		if (wr_hs) begin
			bresp    <= (aw_ctrl || aw_fb) ? RESP_OKAY : RESP_SLVERR;
			fb_waddr <= awaddr[FB_ADDR_W+1:2];
			fb_wdata <= wdata[PIX_W-1:0];
		end
		if (rd_hs) begin
			rdata <= rd_data;
			rresp <= rd_resp;
		end
	end

	// Completed frames, wraps at 16 bits
	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			frame_cnt <= '0;
		else if (frame_done)
			frame_cnt <= frame_cnt + 1'b1;
	end

endmodule

// ==== src/hub75_pkg.sv ====
/*
 * Shared sizes, register map and enums for the HUB75 panel driver
 * Panel is 16 columns by 8 scan rows per bank, two banks, RGB, 4 bit planes
 * Framebuffer word is grouped by plane, bank 0 RGB in the low bits of each plane
 * Register offsets are bytes inside a 4 KiB AXI4-Lite window
 */
package hub75_pkg;

	// Panel geometry
	localparam int N_BANKS      = 2;
	localparam int N_ROWS       = 8;
	localparam int LOG_N_ROWS   = 3;
	localparam int N_COLS       = 16;
	localparam int LOG_N_COLS   = 4;
	localparam int N_CHANS      = 3;
	localparam int BITDEPTH     = 4;
	localparam int LOG_BITDEPTH = 2;

	// Pad data and framebuffer word widths
	localparam int SDW       = N_BANKS * N_CHANS;
	localparam int PIX_W     = SDW * BITDEPTH;
	localparam int FB_ADDR_W = LOG_N_ROWS + LOG_N_COLS;

	// BCM on time, plane p is unblanked for ON_BASE << p cycles
	localparam int ON_BASE = 8;
	// Wide enough to hold the on length of the top plane
	localparam int ON_W    = $clog2(ON_BASE << (BITDEPTH - 1)) + 1;

	// Bus widths and frame counter
	localparam int AXI_ADDR_W = 12;
	localparam int AXI_DATA_W = 32;
	localparam int FCNT_W     = 16;

	// Register map
	localparam logic [AXI_ADDR_W-1:0] REG_CTRL   = 12'h000;
	localparam logic [AXI_ADDR_W-1:0] REG_STATUS = 12'h004;
	localparam logic [AXI_ADDR_W-1:0] FB_BASE    = 12'h400;

	typedef enum logic [1:0] {
		RESP_OKAY   = 2'b00,
		RESP_SLVERR = 2'b10
	} resp_t;

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_SHIFT,
		ST_BLANK,
		ST_LATCH,
		ST_ON,
		ST_NEXT
	} scan_state_t;

endpackage
